/* common/i3c_pkg.sv */
// I3C target package: bus and register constants, FSM state types, shared structs
package i3c_pkg;

    // Bus drivers: 0 controller, 1 simulated target, 2 our target
    localparam int unsigned NUM_DEVICES = 3;

    // SDA transitions with SCL low that arm a target reset
    localparam int unsigned RST_TOGGLES = 14;

    localparam int unsigned CSR_ADDR_W = 2;
    localparam int unsigned CSR_DATA_W = 16;

    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL   = 2'd0;
    localparam logic [CSR_ADDR_W-1:0] CSR_STATUS = 2'd1;
    localparam logic [CSR_ADDR_W-1:0] CSR_CLEAR  = 2'd2;

    // One register access, plain strobes
    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic [CSR_ADDR_W-1:0] addr;
        logic [CSR_DATA_W-1:0] wdata;
    } csr_req_t;

    // CTRL register layout, enable in bit 7
    typedef struct packed {
        logic       enable;
        logic [6:0] own_addr;
    } target_cfg_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic [7:0] rx_count;
        logic       rx_strobe;
    } rx_status_t;

    // Synchronized bus view with decoded conditions
    typedef struct packed {
        logic sda;
        logic scl;
        logic start;
        logic stop;
        logic scl_fall;
    } bus_event_t;

    typedef enum logic [1:0] {
        MON_IDLE,
        MON_ADDR,
        MON_ACK,
        MON_DATA
    } mon_state_t;

    // Reset pattern: counting toggles, armed, seen Sr
    typedef enum logic [1:0] {
        DET_COUNT,
        DET_ARMED,
        DET_SR
    } det_state_t;

endpackage

/* logic/i3c_bus_harness.sv */
// Open-drain bus merge of all device drivers and two-flop synchronizer
`timescale 1ns/1ps

module i3c_bus_harness (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic [i3c_pkg::NUM_DEVICES-1:0] sda_i,
    input  logic [i3c_pkg::NUM_DEVICES-1:0] scl_i,
    output logic                             sda_o,
    output logic                             scl_o,
    output logic                             sda_sync_o,
    output logic                             scl_sync_o
);

    logic [1:0] sda_ff;
    logic [1:0] scl_ff;

    // Any device pulling low wins
    assign sda_o = &sda_i;
    assign scl_o = &scl_i;

    // Idle bus is high, so the synchronizer starts there
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sda_ff <= 2'b11;
            scl_ff <= 2'b11;
        end else begin
            sda_ff <= {sda_ff[0], sda_o};
            scl_ff <= {scl_ff[0], scl_o};
        end
    end

    assign sda_sync_o = sda_ff[1];
    assign scl_sync_o = scl_ff[1];

endmodule

/* i3c_target/i3c_target_csr.sv */
// Target register block: CTRL register, STATUS read mux and count clear strobe
`timescale 1ns/1ps

module i3c_target_csr (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  i3c_pkg::csr_req_t               csr_req_i,
    output logic [i3c_pkg::CSR_DATA_W-1:0] csr_rdata_o,
    output i3c_pkg::target_cfg_t            cfg_o,
    input  i3c_pkg::rx_status_t             rx_i,
    output logic                            clear_count_o
);

    i3c_pkg::target_cfg_t            cfg_q;
    logic [i3c_pkg::CSR_DATA_W-1:0] rdata_mux;
    logic                            ctrl_wr;

    assign ctrl_wr = csr_req_i.wr && (csr_req_i.addr == i3c_pkg::CSR_CTRL);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (ctrl_wr) begin
            cfg_q.enable   <= csr_req_i.wdata[7];
            cfg_q.own_addr <= csr_req_i.wdata[6:0];
        end
    end

    assign cfg_o = cfg_q;

    // Count clears at the same edge as any other write
    assign clear_count_o = csr_req_i.wr && (csr_req_i.addr == i3c_pkg::CSR_CLEAR);

    always_comb begin
        rdata_mux = '0;
        case (csr_req_i.addr)
            i3c_pkg::CSR_CTRL: begin
                rdata_mux[7:0] = cfg_q;
            end
            i3c_pkg::CSR_STATUS: begin
                rdata_mux[7:0]  = rx_i.rx_byte;
                rdata_mux[15:8] = rx_i.rx_count;
            end
            default: begin
                rdata_mux = '0;
            end
        endcase
    end

    // Read data is held until the next read strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            csr_rdata_o <= '0;
        end else if (csr_req_i.rd) begin
            csr_rdata_o <= rdata_mux;
        end
    end

endmodule

/* i3c_target/i3c_bus_monitor.sv */
// Bus monitor: START/STOP detection, bit shifter, address match, ACK and byte counter
`timescale 1ns/1ps

module i3c_bus_monitor (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 sda_sync_i,
    input  logic                 scl_sync_i,
    input  i3c_pkg::target_cfg_t cfg_i,
    input  logic                 clear_count_i,
    output i3c_pkg::bus_event_t  ev_o,
    output i3c_pkg::rx_status_t  rx_o,
    output logic                 sda_o
);

    logic                sda_q;
    logic                scl_q;
    logic                scl_rise;
    logic                byte_done;
    logic                addr_hit;
    logic                data_done;
    logic [3:0]          bit_cnt;
    logic [7:0]          shift_q;
    i3c_pkg::mon_state_t state_q;
    i3c_pkg::rx_status_t rx_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sda_q <= 1'b1;
            scl_q <= 1'b1;
        end else begin
            sda_q <= sda_sync_i;
            scl_q <= scl_sync_i;
        end
    end

    assign scl_rise      = scl_sync_i & ~scl_q;
    assign ev_o.sda      = sda_sync_i;
    assign ev_o.scl      = scl_sync_i;
    assign ev_o.start    = scl_sync_i & scl_q & sda_q & ~sda_sync_i;
    assign ev_o.stop     = scl_sync_i & scl_q & ~sda_q & sda_sync_i;
    assign ev_o.scl_fall = scl_q & ~scl_sync_i;

    // Eighth bit is complete at the following SCL fall
    assign byte_done = (bit_cnt == 4'd8) && ev_o.scl_fall;
    assign addr_hit  = cfg_i.enable && (shift_q[7:1] == cfg_i.own_addr) && !shift_q[0];
    assign data_done = (state_q == i3c_pkg::MON_DATA) && byte_done;

    always_ff @(posedge clk_i) begin
        if (scl_rise) begin
            shift_q <= {shift_q[6:0], sda_sync_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= i3c_pkg::MON_IDLE;
            bit_cnt <= '0;
            sda_o   <= 1'b1;
        end else if (ev_o.start) begin
            state_q <= i3c_pkg::MON_ADDR;
            bit_cnt <= '0;
            sda_o   <= 1'b1;
        end else if (ev_o.stop) begin
            state_q <= i3c_pkg::MON_IDLE;
            sda_o   <= 1'b1;
        end else begin
            case (state_q)
                i3c_pkg::MON_ADDR, i3c_pkg::MON_DATA: begin
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    if (byte_done) begin
                        bit_cnt <= '0;
                        // Later bytes of an acked transfer are acked too
                        if (state_q == i3c_pkg::MON_DATA || addr_hit) begin
                            state_q <= i3c_pkg::MON_ACK;
                            sda_o   <= 1'b0;
                        end else begin
                            state_q <= i3c_pkg::MON_IDLE;
                        end
                    end
                end
                i3c_pkg::MON_ACK: begin
                    // Release after the ninth clock
                    if (ev_o.scl_fall) begin
                        state_q <= i3c_pkg::MON_DATA;
                        sda_o   <= 1'b1;
                    end
                end
                default: begin
                    state_q <= i3c_pkg::MON_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rx_q <= '0;
        end else begin
            rx_q.rx_strobe <= data_done;
            if (data_done) begin
                rx_q.rx_byte <= shift_q;
            end
            if (clear_count_i) begin
                rx_q.rx_count <= '0;
            end else if (data_done) begin
                rx_q.rx_count <= rx_q.rx_count + 8'd1;
            end
        end
    end

    assign rx_o = rx_q;

endmodule

/* i3c_target/i3c_reset_detector.sv */
// Target reset pattern detector with peripheral and escalated reset outputs
`timescale 1ns/1ps

module i3c_reset_detector (
    input  logic                clk_i,
    input  logic                reset_i,
    input  i3c_pkg::bus_event_t ev_i,
    input  logic                peripheral_reset_done_i,
    output logic                peripheral_reset_o,
    output logic                escalated_reset_o
);

    logic                sda_q;
    logic                toggle;
    logic                pattern_done;
    logic [3:0]          toggle_cnt;
    i3c_pkg::det_state_t state_q;

    assign toggle       = ~ev_i.scl && (ev_i.sda != sda_q);
    assign pattern_done = (state_q == i3c_pkg::DET_SR) && ev_i.stop;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= i3c_pkg::DET_COUNT;
            toggle_cnt <= '0;
            sda_q      <= 1'b1;
        end else begin
            sda_q <= ev_i.sda;
            case (state_q)
                i3c_pkg::DET_COUNT: begin
                    // SCL high outside the pattern restarts the count
                    if (ev_i.scl) begin
                        toggle_cnt <= '0;
                    end else if (toggle) begin
                        if (toggle_cnt == 4'(i3c_pkg::RST_TOGGLES - 1)) begin
                            state_q    <= i3c_pkg::DET_ARMED;
                            toggle_cnt <= '0;
                        end else begin
                            toggle_cnt <= toggle_cnt + 4'd1;
                        end
                    end
                end
                i3c_pkg::DET_ARMED: begin
                    if (ev_i.start) begin
                        state_q <= i3c_pkg::DET_SR;
                    end else if (ev_i.scl_fall) begin
                        state_q <= i3c_pkg::DET_COUNT;
                    end
                end
                i3c_pkg::DET_SR: begin
                    if (ev_i.stop || ev_i.scl_fall) begin
                        state_q <= i3c_pkg::DET_COUNT;
                    end
                end
                default: begin
                    state_q <= i3c_pkg::DET_COUNT;
                end
            endcase
        end
    end

    // Second pattern before done escalates
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            peripheral_reset_o <= 1'b0;
            escalated_reset_o  <= 1'b0;
        end else begin
            if (pattern_done && !peripheral_reset_o) begin
                peripheral_reset_o <= 1'b1;
            end else if (peripheral_reset_done_i && !pattern_done) begin
                peripheral_reset_o <= 1'b0;
            end
            if (pattern_done && peripheral_reset_o) begin
                escalated_reset_o <= 1'b1;
            end
        end
    end

endmodule

/* i3c_target/i3c_target.sv */
// Target core: register block, bus monitor and reset detector
`timescale 1ns/1ps

module i3c_target (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  i3c_pkg::csr_req_t               csr_req_i,
    output logic [i3c_pkg::CSR_DATA_W-1:0] csr_rdata_o,
    input  logic                            sda_sync_i,
    input  logic                            scl_sync_i,
    output logic                            sda_o,
    output logic                            peripheral_reset_o,
    input  logic                            peripheral_reset_done_i,
    output logic                            escalated_reset_o
);

    i3c_pkg::target_cfg_t cfg;
    i3c_pkg::rx_status_t  rx;
    i3c_pkg::bus_event_t  ev;
    logic                 clear_count;

    i3c_target_csr u_csr (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .csr_req_i     (csr_req_i),
        .csr_rdata_o   (csr_rdata_o),
        .cfg_o         (cfg),
        .rx_i          (rx),
        .clear_count_o (clear_count)
    );

    i3c_bus_monitor u_monitor (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .sda_sync_i    (sda_sync_i),
        .scl_sync_i    (scl_sync_i),
        .cfg_i         (cfg),
        .clear_count_i (clear_count),
        .ev_o          (ev),
        .rx_o          (rx),
        .sda_o         (sda_o)
    );

    i3c_reset_detector u_reset_det (
        .clk_i                   (clk_i),
        .reset_i                 (reset_i),
        .ev_i                    (ev),
        .peripheral_reset_done_i (peripheral_reset_done_i),
        .peripheral_reset_o      (peripheral_reset_o),
        .escalated_reset_o       (escalated_reset_o)
    );

endmodule

/* logic/i3c_test_top.sv */
// Simulation top: simulated controller and target merged with our target on one bus
`timescale 1ns/1ps

module i3c_test_top (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  i3c_pkg::csr_req_t               csr_req_i,
    output logic [i3c_pkg::CSR_DATA_W-1:0] csr_rdata_o,
    input  logic                            sda_sim_ctrl_i,
    input  logic                            scl_sim_ctrl_i,
    input  logic                            sda_sim_target_i,
    input  logic                            scl_sim_target_i,
    output logic                            bus_sda_o,
    output logic                            bus_scl_o,
    output logic                            peripheral_reset_o,
    input  logic                            peripheral_reset_done_i,
    output logic                            escalated_reset_o
);

    logic [i3c_pkg::NUM_DEVICES-1:0] sda_drv;
    logic [i3c_pkg::NUM_DEVICES-1:0] scl_drv;
    logic                            sda_sync;
    logic                            scl_sync;

    assign sda_drv[0] = sda_sim_ctrl_i;
    assign scl_drv[0] = scl_sim_ctrl_i;
    assign sda_drv[1] = sda_sim_target_i;
    assign scl_drv[1] = scl_sim_target_i;
    // A target never drives SCL
    assign scl_drv[2] = 1'b1;

    i3c_bus_harness u_harness (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .sda_i      (sda_drv),
        .scl_i      (scl_drv),
        .sda_o      (bus_sda_o),
        .scl_o      (bus_scl_o),
        .sda_sync_o (sda_sync),
        .scl_sync_o (scl_sync)
    );

    i3c_target u_target (
        .clk_i                   (clk_i),
        .reset_i                 (reset_i),
        .csr_req_i               (csr_req_i),
        .csr_rdata_o             (csr_rdata_o),
        .sda_sync_i              (sda_sync),
        .scl_sync_i              (scl_sync),
        .sda_o                   (sda_drv[2]),
        .peripheral_reset_o      (peripheral_reset_o),
        .peripheral_reset_done_i (peripheral_reset_done_i),
        .escalated_reset_o       (escalated_reset_o)
    );

endmodule

/* verification/i3c_tb_sva.sv */
// Bound assertions: wired-AND bus, reset output ordering, SDA released after reset
`timescale 1ns/1ps

module i3c_tb_sva (
    input logic                             clk_i,
    input logic                             reset_i,
    input logic [i3c_pkg::NUM_DEVICES-1:0] sda_drv_i,
    input logic [i3c_pkg::NUM_DEVICES-1:0] scl_drv_i,
    input logic                             bus_sda_i,
    input logic                             bus_scl_i,
    input logic                             peripheral_reset_i,
    input logic                             peripheral_reset_done_i,
    input logic                             escalated_reset_i
);

    bus_wired_and: assert property (@(posedge clk_i) disable iff (reset_i)
        (bus_sda_i == &sda_drv_i) && (bus_scl_i == &scl_drv_i))
        else $error("bus lines differ from the AND of the device drivers");

    escalate_needs_peripheral: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(escalated_reset_i) |-> $past(peripheral_reset_i))
        else $error("escalated reset rose while peripheral reset was low");

    peripheral_release: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(peripheral_reset_i) |-> $past(peripheral_reset_done_i))
        else $error("peripheral reset fell without the done input");

    // Our target is slot 2
    sda_released: assert property (@(posedge clk_i)
        reset_i |=> sda_drv_i[2])
        else $error("target SDA driver not released after reset");

endmodule

bind i3c_test_top i3c_tb_sva u_sva (
    .clk_i                   (clk_i),
    .reset_i                 (reset_i),
    .sda_drv_i               (sda_drv),
    .scl_drv_i               (scl_drv),
    .bus_sda_i               (bus_sda_o),
    .bus_scl_i               (bus_scl_o),
    .peripheral_reset_i      (peripheral_reset_o),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .escalated_reset_i       (escalated_reset_o)
);

/* verification/i3c_tb.sv */
// Testbench for the I3C target subsystem: controller bus model, register accesses, checks
`timescale 1ns/1ps

module i3c_tb;

    localparam int unsigned RESET_CYCLES   = 5;
    localparam int unsigned PHASE_CYCLES   = 8;
    localparam int unsigned MID_CYCLES     = 4;
    // Ten bytes of nine bits, three reset patterns, slack for starts, stops and registers
    localparam int unsigned TOTAL_BITS     = 90;
    localparam int unsigned PATTERN_CYCLES = i3c_pkg::RST_TOGGLES * MID_CYCLES + 40;
    localparam int unsigned MAX_CYCLES     = TOTAL_BITS * 2 * PHASE_CYCLES
                                             + 3 * PATTERN_CYCLES + 1000;
    localparam logic [6:0]  OWN_ADDR       = 7'h2a;
    localparam logic [6:0]  OTHER_ADDR     = 7'h15;

    logic              clk = 1'b0;
    logic              reset;
    i3c_pkg::csr_req_t csr_req;
    logic [15:0]       csr_rdata;
    logic              sda_ctrl;
    logic              scl_ctrl;
    logic              sda_tgt;
    logic              scl_tgt;
    logic              bus_sda;
    logic              bus_scl;
    logic              periph_rst;
    logic              periph_done;
    logic              esc_rst;
    logic [31:0]       lcg_state = 32'd60719;
    logic [7:0]        exp_byte = 8'h00;
    logic [7:0]        exp_count = 8'h00;
    int unsigned       cycle_count = 0;

    i3c_test_top DUT (
        .clk_i                   (clk),
        .reset_i                 (reset),
        .csr_req_i               (csr_req),
        .csr_rdata_o             (csr_rdata),
        .sda_sim_ctrl_i          (sda_ctrl),
        .scl_sim_ctrl_i          (scl_ctrl),
        .sda_sim_target_i        (sda_tgt),
        .scl_sim_target_i        (scl_tgt),
        .bus_sda_o               (bus_sda),
        .bus_scl_o               (bus_scl),
        .peripheral_reset_o      (periph_rst),
        .peripheral_reset_done_i (periph_done),
        .escalated_reset_o       (esc_rst)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(posedge clk);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        csr_req.wr    <= 1'b1;
        csr_req.addr  <= addr;
        csr_req.wdata <= data;
        @(posedge clk);
        csr_req.wr <= 1'b0;
    endtask

    // Data arrives one cycle after the read strobe
    task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
        @(posedge clk);
        csr_req.rd   <= 1'b1;
        csr_req.addr <= addr;
        @(posedge clk);
        csr_req.rd <= 1'b0;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic send_start();
        wait_cycles(PHASE_CYCLES);
        sda_ctrl <= 1'b0;
        wait_cycles(PHASE_CYCLES);
        scl_ctrl <= 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(MID_CYCLES);
        sda_ctrl <= 1'b0;
        wait_cycles(MID_CYCLES);
        scl_ctrl <= 1'b1;
        wait_cycles(MID_CYCLES);
        sda_ctrl <= 1'b1;
        wait_cycles(PHASE_CYCLES);
    endtask

    // SDA changes mid-low, bus sampled mid-high
    task automatic clock_bit(input logic b, output logic level);
        wait_cycles(MID_CYCLES);
        sda_ctrl <= b;
        wait_cycles(MID_CYCLES);
        scl_ctrl <= 1'b1;
        wait_cycles(MID_CYCLES);
        @(negedge clk);
        level = bus_sda;
        wait_cycles(MID_CYCLES);
        scl_ctrl <= 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack_level);
        logic [7:0] sh;
        logic       bit_level;
        sh = b;
        repeat (8) begin
            clock_bit(sh[7], bit_level);
            // Only the controller drives SDA during the data bits
            check_value("bus_sda_o", 16'(sh[7]), 16'(bit_level));
            sh = {sh[6:0], 1'b0};
        end
        clock_bit(1'b1, ack_level);
    endtask

    task automatic run_transfer(input logic [6:0] addr, input logic rnw,
                                input int unsigned nbytes, input logic acked);
        logic       level;
        logic [7:0] data;
        send_start();
        send_byte({addr, rnw}, level);
        check_value("bus_sda_o", 16'(!acked), 16'(level));
        repeat (nbytes) begin
            lcg_state = lcg_step(lcg_state);
            data = lcg_state[23:16];
            send_byte(data, level);
            check_value("bus_sda_o", 16'(!acked), 16'(level));
            if (acked) begin
                exp_byte  = data;
                exp_count = exp_count + 8'd1;
            end
        end
        send_stop();
    endtask

    task automatic send_reset_pattern(input logic pull_target);
        int unsigned i;
        wait_cycles(MID_CYCLES);
        scl_ctrl <= 1'b0;
        for (i = 0; i < i3c_pkg::RST_TOGGLES; i++) begin
            if (pull_target && i == 0) begin
                // Second target pulls SDA low a cycle before the controller
                wait_cycles(MID_CYCLES - 1);
                sda_tgt <= 1'b0;
                wait_cycles(1);
                sda_ctrl <= i[0];
                wait_cycles(2);
                sda_tgt <= 1'b1;
            end else begin
                wait_cycles(MID_CYCLES);
                sda_ctrl <= i[0];
            end
        end
        // Repeated START then STOP
        wait_cycles(MID_CYCLES);
        scl_ctrl <= 1'b1;
        wait_cycles(MID_CYCLES);
        sda_ctrl <= 1'b0;
        wait_cycles(MID_CYCLES);
        sda_ctrl <= 1'b1;
        wait_cycles(PHASE_CYCLES);
        @(negedge clk);
    endtask

    initial begin : stimulus
        logic [15:0] rdata;
        reset       <= 1'b1;
        csr_req     <= '0;
        sda_ctrl    <= 1'b1;
        scl_ctrl    <= 1'b1;
        sda_tgt     <= 1'b1;
        scl_tgt     <= 1'b1;
        periph_done <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        wait_cycles(2);

        write_reg(i3c_pkg::CSR_CTRL, {8'h00, 1'b1, OWN_ADDR});
        read_reg(i3c_pkg::CSR_CTRL, rdata);
        check_value("csr_rdata_o", {8'h00, 1'b1, OWN_ADDR}, rdata);

        run_transfer(OWN_ADDR, 1'b0, 3, 1'b1);
        read_reg(i3c_pkg::CSR_STATUS, rdata);
        check_value("rx_byte", {8'h00, exp_byte}, {8'h00, rdata[7:0]});
        check_value("rx_count", 16'd3, {8'h00, rdata[15:8]});

        // Wrong address, read bit, then target disabled
        run_transfer(OTHER_ADDR, 1'b0, 1, 1'b0);
        run_transfer(OWN_ADDR, 1'b1, 1, 1'b0);
        write_reg(i3c_pkg::CSR_CTRL, {8'h00, 1'b0, OWN_ADDR});
        run_transfer(OWN_ADDR, 1'b0, 1, 1'b0);
        read_reg(i3c_pkg::CSR_STATUS, rdata);
        check_value("csr_rdata_o", {exp_count, exp_byte}, rdata);
        write_reg(i3c_pkg::CSR_CLEAR, 16'h0000);
        exp_count = 8'h00;
        read_reg(i3c_pkg::CSR_STATUS, rdata);
        check_value("rx_count", {8'h00, exp_count}, {8'h00, rdata[15:8]});

        send_reset_pattern(1'b0);
        check_value("peripheral_reset_o", 16'd1, 16'(periph_rst));
        wait_cycles(20);
        @(negedge clk);
        check_value("peripheral_reset_o", 16'd1, 16'(periph_rst));
        @(posedge clk);
        periph_done <= 1'b1;
        @(posedge clk);
        periph_done <= 1'b0;
        @(negedge clk);
        check_value("peripheral_reset_o", 16'd0, 16'(periph_rst));
        check_value("escalated_reset_o", 16'd0, 16'(esc_rst));

        // No done between the two patterns
        send_reset_pattern(1'b1);
        check_value("peripheral_reset_o", 16'd1, 16'(periph_rst));
        check_value("escalated_reset_o", 16'd0, 16'(esc_rst));
        send_reset_pattern(1'b0);
        check_value("escalated_reset_o", 16'd1, 16'(esc_rst));

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* build.f */
common/i3c_pkg.sv
logic/i3c_bus_harness.sv
i3c_target/i3c_target_csr.sv
i3c_target/i3c_bus_monitor.sv
i3c_target/i3c_reset_detector.sv
i3c_target/i3c_target.sv
logic/i3c_test_top.sv
verification/i3c_tb_sva.sv
verification/i3c_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module i3c_tb -f build.f

output=$(./obj_dir/Vi3c_tb) || true
echo "$output"

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
